// ==== test/hps_fabric_testdata.txt ====
# columns: id(dec) key(hex) sw(hex) led_pio(hex) reset_req(hex) hold_cycles(dec) exp_key(hex)
# key changes need 8 stable cycles, shorter glitches leave the debounced keys alone
1 f 000 000 0 10 f
1 e 001 001 0 8 e
1 f 002 002 0 8 f
2 d 003 004 0 7 f
2 f 004 008 0 4 f
2 7 005 010 0 3 f
2 f 006 020 0 1 f
3 0 3ff 1ff 0 12 0
3 5 155 0aa 0 8 5
3 a 2aa 155 0 8 a
4 f 100 040 0 5 a
4 a 080 080 0 3 a
4 f 040 100 0 9 f
5 b 020 000 0 7 f
5 b 010 001 0 1 b
5 f 008 002 0 8 f
6 e 004 004 0 20 e
6 f 000 000 0 8 f

// ==== hps_fabric.f ====
common/board_pkg.sv
debounce/key_debounce.sv
reset_pulse/reset_pulse_gen.sv
logic/heartbeat.sv
logic/hps_fabric_top.sv
test/tb_hps_fabric_top.sv

// ==== Makefile ====
# verilator build of the fabric testbench

TOP = tb_hps_fabric_top

.PHONY: compile run clean

compile:
	verilator --binary --assert -f hps_fabric.f --top-module $(TOP) -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== test/tb_hps_fabric_top.sv ====
// self-checking fabric testbench that replays the testdata steps and checks pulses and blinking
`timescale 1ns/1ps

module tb_hps_fabric_top;

  localparam int db_cycles    = 8;   // shortened debounce
  localparam int hb_cycles    = 20;  // shortened heartbeat half period
  localparam int cold_cycles  = 6;
  localparam int warm_cycles  = 2;
  localparam int debug_cycles = 32;

  logic                   fpga_clk_50      = 1'b0;
  logic                   hps_fpga_reset_n = 1'b0;
  board_pkg::key_vec_t    key              = 4'hf;  // idle with nothing pressed
  board_pkg::sw_vec_t     sw               = '0;
  board_pkg::led_pio_t    led_pio          = '0;
  board_pkg::reset_req_t  reset_req        = '0;
  logic [9:0]             ledr;
  board_pkg::key_vec_t    debounced_key;
  board_pkg::reset_req_t  reset_pulse;
  board_pkg::stm_events_t stm_events;

  int          errors       = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycle_cnt    = 0;
  int          cycle_limit  = 500;          // step holds added on load
  logic [31:0] rng_state    = 32'h5d9fa82a;
  logic [3:0]  key_model    = 4'hf;         // debounced keys per the step list

  // step list with one entry per data line
  int         step_id[$];
  int         step_hold[$];
  logic [3:0] step_key[$];
  logic [9:0] step_sw[$];
  logic [8:0] step_led[$];
  logic [2:0] step_req[$];
  logic [3:0] step_exp[$];

  hps_fabric_top #(
    .debounce_cycles    (db_cycles),
    .debounce_cnt_w     (4),
    .cold_pulse_cycles  (cold_cycles),
    .warm_pulse_cycles  (warm_cycles),
    .debug_pulse_cycles (debug_cycles),
    .heartbeat_cycles   (hb_cycles)
  ) uut (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .sw               (sw),
    .led_pio          (led_pio),
    .reset_req        (reset_req),
    .ledr             (ledr),
    .debounced_key    (debounced_key),
    .reset_pulse      (reset_pulse),
    .stm_events       (stm_events)
  );

  always #50 fpga_clk_50 = ~fpga_clk_50;  // 100 ns period

  // ========================================
  // run limit
  // ========================================
  always @(posedge fpga_clk_50)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("the run timed out after %0d clock cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic pulse_bit(input int sel);
    case (sel)
      0:       return reset_pulse.cold;
      1:       return reset_pulse.warm;
      default: return reset_pulse.debug;
    endcase
  endfunction

  task automatic set_req(input int sel, input logic v);
    case (sel)
      0:       reset_req.cold = v;
      1:       reset_req.warm = v;
      default: reset_req.debug = v;
    endcase
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic load_steps();
    int         fd;
    int         n;
    string      line;
    int         t_id;
    int         t_hold;
    logic [3:0] t_key;
    logic [9:0] t_sw;
    logic [8:0] t_led;
    logic [2:0] t_req;
    logic [3:0] t_exp;
    fd = $fopen("test/hps_fabric_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("the step list test/hps_fabric_testdata.txt could not be opened");
      $display("TEST FAILED");
      $finish;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        n = 0;
        if (line.len() > 0 && line[0] != "#")  // skip column notes
          n = $sscanf(line, "%d %h %h %h %h %d %h", t_id, t_key, t_sw, t_led, t_req,
                      t_hold, t_exp);
        if (n == 7)
        begin
          step_id.push_back(t_id);
          step_key.push_back(t_key);
          step_sw.push_back(t_sw);
          step_led.push_back(t_led);
          step_req.push_back(t_req);
          step_hold.push_back(t_hold);
          step_exp.push_back(t_exp);
          cycle_limit += t_hold;
        end
      end
      $fclose(fd);
    end
  endtask

  // ========================================
  // checks
  // ========================================
  task automatic check_heartbeat();
    int   err_before;
    int   len;
    logic prev;
    err_before = errors;
    prev       = ledr[0];
    for (int hp = 0; hp < 4; hp++)
    begin
      len = 0;
      do
      begin
        @(negedge fpga_clk_50);
        len++;
      end
      while (ledr[0] == prev && len < 2 * hb_cycles);
      assert (len == hb_cycles)
      else
      begin
        errors++;
        $display("Error: %0t ns: heartbeat half period %0d took %0d cycles, expected %0d",
                 $time, hp, len, hb_cycles);
      end
      prev = ledr[0];
    end
    report_test("heartbeat", err_before);
  endtask

  // raises a request edge and counts the high cycles
  // retrigger adds a second edge mid pulse
  task automatic check_pulse(input string name, input int sel, input int exp_len,
                             input bit retrigger);
    int err_before;
    int waited;
    int high_cnt;
    err_before = errors;
    set_req(sel, 1'b1);
    waited = 0;
    do
    begin
      @(negedge fpga_clk_50);
      waited++;
    end
    while (!pulse_bit(sel) && waited < 2);
    assert (pulse_bit(sel))
    else
    begin
      errors++;
      $display("Error: %0t ns: %s pulse did not start within two cycles", $time, name);
    end
    high_cnt = 0;
    while (pulse_bit(sel) && high_cnt <= exp_len + 4)
    begin
      high_cnt++;
      if (retrigger && high_cnt == 10)
        set_req(sel, 1'b0);
      if (retrigger && high_cnt == 12)
        set_req(sel, 1'b1);  // new edge while busy
      @(negedge fpga_clk_50);
    end
    assert (high_cnt == exp_len)
    else
    begin
      errors++;
      $display("Error: %0t ns: %s pulse high for %0d cycles, expected %0d",
               $time, name, high_cnt, exp_len);
    end
    if (retrigger)
    begin
      repeat (40)
      begin
        @(negedge fpga_clk_50);
        assert (!pulse_bit(sel))
        else
        begin
          errors++;
          $display("Error: %0t ns: %s pulse restarted after the busy edge", $time, name);
        end
      end
    end
    set_req(sel, 1'b0);
    @(negedge fpga_clk_50);  // let the edge register see low
    report_test(name, err_before);
  endtask

  task automatic run_steps();
    int          err_before;
    logic [27:0] exp_word;
    err_before = errors;
    for (int i = 0; i < step_id.size(); i++)
    begin
      key       = step_key[i];
      sw        = step_sw[i];
      led_pio   = step_led[i];
      reset_req = step_req[i];
      repeat (step_hold[i]) @(negedge fpga_clk_50);
      key_model = step_exp[i];
      exp_word  = {5'b0, step_sw[i], step_led[i], step_exp[i]};  // keys from the debouncer
      assert (debounced_key == step_exp[i])
      else
      begin
        errors++;
        $display("Error: %0t ns: step %0d debounced_key %h, expected %h",
                 $time, i, debounced_key, step_exp[i]);
      end
      assert (stm_events == exp_word)
      else
      begin
        errors++;
        $display("Error: %0t ns: step %0d stm_events %h, expected %h",
                 $time, i, stm_events, exp_word);
      end
      if (i == step_id.size() - 1 || step_id[i + 1] != step_id[i])
      begin
        report_test($sformatf("debounce group %0d", step_id[i]), err_before);
        err_before = errors;
      end
    end
  endtask

  task automatic check_passthrough();
    int          err_before;
    logic [27:0] exp_word;
    err_before = errors;
    for (int i = 0; i < 16; i++)
    begin
      rng_state = lcg_next(rng_state);
      sw        = rng_state[31:22];
      rng_state = lcg_next(rng_state);
      led_pio   = rng_state[31:23];
      @(negedge fpga_clk_50);
      exp_word = {5'b0, sw, led_pio, key_model};  // pad, sw, led word, keys
      assert (stm_events == exp_word)
      else
      begin
        errors++;
        $display("Error: %0t ns: stm_events %h, expected %h", $time, stm_events, exp_word);
      end
      assert (ledr[9:1] == led_pio)
      else
      begin
        errors++;
        $display("Error: %0t ns: ledr[9:1] %h, expected %h", $time, ledr[9:1], led_pio);
      end
    end
    report_test("pass-through", err_before);
  endtask

  // ========================================
  // sequence
  // ========================================
  initial
  begin
    int err_before;
    load_steps();
    repeat (5) @(negedge fpga_clk_50);
    hps_fpga_reset_n = 1'b1;
    err_before = errors;
    assert (debounced_key == 4'hf && ledr[0] == 1'b0)
    else
    begin
      errors++;
      $display("Error: %0t ns: after reset keys %h led %b, expected f and 0",
               $time, debounced_key, ledr[0]);
    end
    report_test("reset values", err_before);
    check_heartbeat();  // counts from reset release
    check_pulse("cold", 0, cold_cycles, 1'b0);
    check_pulse("warm", 1, warm_cycles, 1'b0);
    check_pulse("debug", 2, debug_cycles, 1'b0);
    check_pulse("debug retrigger", 2, debug_cycles, 1'b1);
    run_steps();
    check_passthrough();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== logic/hps_fabric_top.sv ====
// fabric top, debounces keys, stretches hps reset requests, blinks ledr[0] and packs the stm event word
`timescale 1ns/1ps

module hps_fabric_top #(
  parameter int debounce_cycles    = 50000,     // 1 ms at 50 MHz
  parameter int debounce_cnt_w     = 16,
  parameter int cold_pulse_cycles  = 6,
  parameter int warm_pulse_cycles  = 2,
  parameter int debug_pulse_cycles = 32,
  parameter int heartbeat_cycles   = 25000000   // 0.5 s half period
) (
  input  logic                          fpga_clk_50,
  input  logic                          hps_fpga_reset_n,
  input  board_pkg::key_vec_t           key,        // raw push keys, active low
  input  board_pkg::sw_vec_t            sw,
  input  board_pkg::led_pio_t           led_pio,    // led word from the hps
  input  board_pkg::reset_req_t         reset_req,  // raw reset requests
  output logic [board_pkg::led_pio_w:0] ledr,
  output board_pkg::key_vec_t           debounced_key,
  output board_pkg::reset_req_t         reset_pulse,
  output board_pkg::stm_events_t        stm_events
);

  logic heartbeat_led;
  logic cold_pulse;
  logic warm_pulse;
  logic debug_pulse;

  // ========================================
  // keys
  // ========================================
  key_debounce #(
    .width           (board_pkg::key_w),
    .polarity        (board_pkg::active_low),
    .debounce_cycles (debounce_cycles),
    .cnt_w           (debounce_cnt_w)
  ) u_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .data_in          (key),
    .data_out         (debounced_key)
  );

  // ========================================
  // hps reset request stretchers
  // ========================================
  reset_pulse_gen #(
    .edge_type    (board_pkg::edge_rising),
    .pulse_cycles (cold_pulse_cycles)
  ) u_pulse_cold (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .signal_in        (reset_req.cold),
    .pulse_out        (cold_pulse)
  );

  reset_pulse_gen #(
    .edge_type    (board_pkg::edge_rising),
    .pulse_cycles (warm_pulse_cycles)
  ) u_pulse_warm (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .signal_in        (reset_req.warm),
    .pulse_out        (warm_pulse)
  );

  reset_pulse_gen #(
    .edge_type    (board_pkg::edge_rising),
    .pulse_cycles (debug_pulse_cycles)  // longest of the three
  ) u_pulse_debug (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .signal_in        (reset_req.debug),
    .pulse_out        (debug_pulse)
  );

  assign reset_pulse = '{cold: cold_pulse, warm: warm_pulse, debug: debug_pulse};

  // ========================================
  // leds and event word
  // ========================================
  heartbeat #(
    .heartbeat_cycles (heartbeat_cycles)
  ) u_heartbeat (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led              (heartbeat_led)
  );

  assign ledr = {led_pio, heartbeat_led};  // hps word above the blinker

  // combinational, no added latency
  assign stm_events = '{pad: '0, sw: sw, led_pio: led_pio, keys: debounced_key};

endmodule

// ==== logic/heartbeat.sv ====
// free-running divider that blinks the heartbeat led, one toggle per heartbeat_cycles clocks
`timescale 1ns/1ps

module heartbeat #(
  parameter int heartbeat_cycles = 25000000  // half period in clocks
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led
);

  localparam int cnt_w = (heartbeat_cycles > 1) ? $clog2(heartbeat_cycles) : 1;
  localparam logic [cnt_w-1:0] wrap_cnt = cnt_w'(heartbeat_cycles - 1);

  logic [cnt_w-1:0] cnt;
  logic             led_q;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt   <= '0;
      led_q <= 1'b0;  // dark out of reset
    end
    else if (cnt == wrap_cnt)
    begin
      cnt   <= '0;
      led_q <= ~led_q;  // half period done
    end
    else
      cnt <= cnt + 1'b1;
  end

  assign led = led_q;

endmodule

// ==== reset_pulse/reset_pulse_gen.sv ====
// edge detector that stretches a detected edge into a fixed-length pulse, new edges ignored while busy
`timescale 1ns/1ps

module reset_pulse_gen #(
  parameter board_pkg::edge_type_e edge_type    = board_pkg::edge_rising,
  parameter int                    pulse_cycles = 6  // pulse length in clocks
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic signal_in,
  output logic pulse_out
);

  // counter only needs pulse_cycles - 1
  localparam int cnt_w = (pulse_cycles > 1) ? $clog2(pulse_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_load = cnt_w'(pulse_cycles - 1);

  logic             signal_q;   // previous input value
  logic             edge_seen;  // selected edge between register and live input
  logic [cnt_w-1:0] cnt;        // remaining cycles after the current one
  logic             pulse_q;

  // ========================================
  // edge select
  // ========================================
  always_comb
  begin
    case (edge_type)
      board_pkg::edge_rising:  edge_seen = signal_in & ~signal_q;
      board_pkg::edge_falling: edge_seen = ~signal_in & signal_q;
      default:                 edge_seen = signal_in ^ signal_q;  // either way
    endcase
  end

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      signal_q <= 1'b0;
    else
      signal_q <= signal_in;
  end

  // ========================================
  // pulse stretch
  // ========================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt     <= '0;
      pulse_q <= 1'b0;
    end
    else if (pulse_q)
    begin
      // busy, edges fall through here unseen
      if (cnt == '0)
        pulse_q <= 1'b0;
      else
        cnt <= cnt - 1'b1;
    end
    else if (edge_seen)
    begin
      cnt     <= cnt_load;  // high for cnt_load + 1 cycles
      pulse_q <= 1'b1;
    end
  end

  assign pulse_out = pulse_q;

endmodule

// ==== debounce/key_debounce.sv ====
// per-bit input debouncer whose output follows an input level once it is stable for a set count
`timescale 1ns/1ps

module key_debounce #(
  parameter int                   width           = 4,
  parameter board_pkg::polarity_e polarity        = board_pkg::active_low,
  parameter int                   debounce_cycles = 50000,  // 1 ms at 50 MHz
  parameter int                   cnt_w           = 16      // holds debounce_cycles - 1
) (
  input  logic             fpga_clk_50,
  input  logic             hps_fpga_reset_n,
  input  logic [width-1:0] data_in,
  output logic [width-1:0] data_out
);

  // level the output sits at out of reset
  localparam logic idle_level = (polarity == board_pkg::active_low) ? 1'b1 : 1'b0;

  // count value on the last of debounce_cycles differing samples
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(debounce_cycles - 1);

  // ========================================
  // one counter and state per bit
  // ========================================
  for (genvar i = 0; i < width; i++)
  begin : g_bit
    logic                       level;    // debounced level of this bit
    logic [cnt_w-1:0]           cnt;      // differing samples seen so far
    board_pkg::debounce_state_e state;
    logic                       differs;  // live sample != output
    logic [cnt_w-1:0]           run_len;  // samples already in this run

    assign differs  = data_in[i] ^ level;
    assign run_len  = (state == board_pkg::db_counting) ? cnt : '0;  // fresh run from stable
    assign data_out[i] = level;

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        level <= idle_level;
        cnt   <= '0;
        state <= board_pkg::db_stable;
      end
      else if (!differs)
      begin
        // bounced back so the run is dropped
        state <= board_pkg::db_stable;
      end
      else if (run_len == last_cnt)
      begin
        level <= data_in[i];  // stable long enough so take it
        state <= board_pkg::db_stable;
      end
      else
      begin
        cnt   <= run_len + 1'b1;
        state <= board_pkg::db_counting;
      end
    end
  end

endmodule

// ==== common/board_pkg.sv ====
// shared widths, packed event/reset structs and enums for the hps fabric logic, used by scoped name
package board_pkg;

  // ========================================
  // board widths
  // ========================================
  localparam int key_w     = 4;   // push keys KEY[3:0]
  localparam int sw_w      = 10;  // slide switches SW[9:0]
  localparam int led_pio_w = 9;   // hps led word, lands on LEDR[9:1]
  localparam int stm_w     = 28;  // stm hw event word into the hps

  // zero pad on top of the event word
  localparam int stm_pad_w = stm_w - sw_w - led_pio_w - key_w;

  // ========================================
  // vectors and structs
  // ========================================
  typedef logic [key_w-1:0]     key_vec_t;  // raw or debounced key levels
  typedef logic [sw_w-1:0]      sw_vec_t;   // switch levels
  typedef logic [led_pio_w-1:0] led_pio_t;  // led word from the hps pio

  // hps reset requests, raw from the request port or stretched
  typedef struct packed {
    logic cold;   // cold reset
    logic warm;   // warm reset
    logic debug;  // debug reset
  } reset_req_t;

  // stm hw events, msb first
  typedef struct packed {
    logic [stm_pad_w-1:0] pad;      // always zero
    sw_vec_t              sw;       // switches straight through
    led_pio_t             led_pio;  // hps led word
    key_vec_t             keys;     // debounced keys
  } stm_events_t;

  // ========================================
  // enums
  // ========================================
  // idle level convention of a debounced input
  typedef enum logic {
    active_low  = 1'b0,  // idles high, pressed = 0
    active_high = 1'b1   // idles low
  } polarity_e;

  // which transition fires the pulse generator
  typedef enum logic [1:0] {
    edge_rising  = 2'd0,
    edge_falling = 2'd1,
    edge_any     = 2'd2
  } edge_type_e;

  // per-bit debouncer state
  typedef enum logic {
    db_stable   = 1'b0,  // sample matches output
    db_counting = 1'b1   // sample differs, counting stable samples
  } debounce_state_e;

endpackage
